/* common/i2cPkg.sv */
package i2cPkg;

	// one quarter of an SCL period in I2Cclk cycles, 125 gives 100 kHz from 50 MHz
	localparam int quarterTicks = 4;
	localparam int quarterW = $clog2(quarterTicks);

	localparam int idleBits = 2; // bus idle between transactions, in bit times
	localparam int gapCycles = idleBits * 4 * quarterTicks;
	localparam int gapW = $clog2(gapCycles);

	localparam logic [6:0] sensorAddr = 7'h48;
	localparam logic [7:0] pointerReg = 8'h00; // temperature register

	// hex digit to segments, bit order g down to a
	localparam logic [15:0][6:0] segTable = {
		7'h71, 7'h79, 7'h5E, 7'h39, 7'h7C, 7'h77, 7'h6F, 7'h7F,
		7'h07, 7'h7D, 7'h6D, 7'h66, 7'h4F, 7'h5B, 7'h06, 7'h3F
	};

	typedef enum logic [3:0] {
		stIdle,
		stStart,
		stAddrW,
		stPointer,
		stRestart,
		stAddrR,
		stReadHi,
		stReadLo,
		stStop,
		stGap
	} seqState_t;

	typedef enum logic [1:0] {
		opStart,
		opStop,
		opWrite,
		opRead
	} shiftOp_t;

	typedef struct packed {
		shiftOp_t op;
		logic [7:0] txByte;
		logic masterAck; // 0 acknowledges the byte read
	} shiftCmd_t;

	typedef struct packed {
		logic [7:0] rxByte;
		logic slaveNack;
	} shiftResult_t;

	typedef struct packed {
		logic addrWNack;
		logic pointerNack;
		logic addrRNack;
	} ackStatus_t;

	typedef logic [15:0] sensorReading_t;

	typedef struct packed {
		logic [6:0] digit3;
		logic [6:0] digit2;
		logic [6:0] digit1;
		logic [6:0] digit0;
	} segDisplay_t;

endpackage

/* filelist.f */
common/i2cPkg.sv
i2cMaster/sclTimer.sv
i2cMaster/i2cShifter.sv
i2cMaster/i2cSequencer.sv
hdl/sevenSegDecode.sv
hdl/sensorReaderTop.sv
tb/sensorReader_props.sv
tb/sensorReaderTb.sv

/* hdl/sensorReaderTop.sv */
`timescale 1ns/1ns

module sensorReaderTop import i2cPkg::*; (
	input logic I2Cclk,
	input logic reset,
	input logic sdaIn,
	output logic sdaDriveLow,
	output logic scl,
	output segDisplay_t segments,
	output sensorReading_t reading,
	output logic readingValid,
	output ackStatus_t ackStatus
);

	logic tick;
	logic [1:0] phase;
	shiftCmd_t cmd;
	logic cmdGo;
	logic busy;
	logic done;
	shiftResult_t result;

	sclTimer i_sclTimer (
		.I2Cclk(I2Cclk),
		.reset(reset),
		.tick(tick),
		.phase(phase)
	);

	i2cShifter i_i2cShifter (
		.I2Cclk(I2Cclk),
		.reset(reset),
		.tick(tick),
		.phase(phase),
		.cmd(cmd),
		.cmdGo(cmdGo),
		.sdaIn(sdaIn),
		.sdaDriveLow(sdaDriveLow),
		.scl(scl),
		.busy(busy),
		.done(done),
		.result(result)
	);

	i2cSequencer i_i2cSequencer (
		.I2Cclk(I2Cclk),
		.reset(reset),
		.busy(busy),
		.done(done),
		.result(result),
		.cmd(cmd),
		.cmdGo(cmdGo),
		.ackStatus(ackStatus),
		.reading(reading),
		.readingValid(readingValid)
	);

	sevenSegDecode i_sevenSegDecode (
		.I2Cclk(I2Cclk),
		.reset(reset),
		.reading(reading),
		.readingValid(readingValid),
		.segments(segments)
	);

endmodule

/* hdl/sevenSegDecode.sv */
`timescale 1ns/1ns

module sevenSegDecode import i2cPkg::*; (
	input logic I2Cclk,
	input logic reset,
	input sensorReading_t reading,
	input logic readingValid,
	output segDisplay_t segments
);

	logic [3:0] nib3;
	logic [3:0] nib2;
	logic [3:0] nib1;
	logic [3:0] nib0;

	assign nib3 = reading[15:12];
	assign nib2 = reading[11:8];
	assign nib1 = reading[7:4];
	assign nib0 = reading[3:0];

	always_ff @(posedge I2Cclk) begin
		if (reset) begin
			segments.digit3 <= segTable[0]; // display reads 0000 until the first value
			segments.digit2 <= segTable[0];
			segments.digit1 <= segTable[0];
			segments.digit0 <= segTable[0];
		end else if (readingValid) begin
			segments.digit3 <= segTable[nib3];
			segments.digit2 <= segTable[nib2];
			segments.digit1 <= segTable[nib1];
			segments.digit0 <= segTable[nib0];
		end
	end

endmodule

/* i2cMaster/i2cSequencer.sv */
`timescale 1ns/1ns

module i2cSequencer import i2cPkg::*; (
	input logic I2Cclk,
	input logic reset,
	input logic busy,
	input logic done,
	input shiftResult_t result,
	output shiftCmd_t cmd,
	output logic cmdGo,
	output ackStatus_t ackStatus,
	output sensorReading_t reading,
	output logic readingValid
);

	seqState_t state;
	logic issued;
	logic [gapW-1:0] gapCnt;
	logic [7:0] hiByte;

	// the command follows the state, the shifter latches it on cmdGo
	always_comb begin
		cmd.op = opStop;
		cmd.txByte = 8'h00;
		cmd.masterAck = 1'b1;
		case (state)
			stStart, stRestart: cmd.op = opStart;
			stAddrW: begin
				cmd.op = opWrite;
				cmd.txByte = {sensorAddr, 1'b0};
			end
			stPointer: begin
				cmd.op = opWrite;
				cmd.txByte = pointerReg;
			end
			stAddrR: begin
				cmd.op = opWrite;
				cmd.txByte = {sensorAddr, 1'b1};
			end
			stReadHi: begin
				cmd.op = opRead;
				cmd.masterAck = 1'b0;
			end
			stReadLo: begin
				cmd.op = opRead;
				cmd.masterAck = 1'b1; // NACK ends the read
			end
			default: cmd.op = opStop;
		endcase
	end

	always_ff @(posedge I2Cclk) begin
		if (reset) begin
			state <= stIdle;
			issued <= 1'b0;
			cmdGo <= 1'b0;
			gapCnt <= '0;
			ackStatus <= '0;
			reading <= '0;
			readingValid <= 1'b0;
		end else begin
			cmdGo <= 1'b0;
			readingValid <= 1'b0;
			case (state)
				stIdle: state <= stStart;
				stGap: begin
					if (gapCnt == gapW'(gapCycles - 1)) begin
						gapCnt <= '0;
						state <= stStart;
					end else begin
						gapCnt <= gapCnt + 1'b1;
					end
				end
				default: begin
					if (!issued && !busy) begin
						cmdGo <= 1'b1;
						issued <= 1'b1;
						if (state == stStart) begin
							ackStatus <= '0;
						end
					end else if (done) begin
						issued <= 1'b0;
						case (state)
							stStart: state <= stAddrW;
							stAddrW: begin
								ackStatus.addrWNack <= result.slaveNack;
								state <= result.slaveNack ? stStop : stPointer;
							end
							stPointer: begin
								ackStatus.pointerNack <= result.slaveNack;
								state <= result.slaveNack ? stStop : stRestart;
							end
							stRestart: state <= stAddrR;
							stAddrR: begin
								ackStatus.addrRNack <= result.slaveNack;
								state <= result.slaveNack ? stStop : stReadHi;
							end
							stReadHi: state <= stReadLo;
							stReadLo: begin
								reading <= {hiByte, result.rxByte};
								readingValid <= 1'b1;
								state <= stStop;
							end
							default: state <= stGap; // STOP is on the bus
						endcase
					end
				end
			endcase
		end
	end

	always_ff @(posedge I2Cclk) begin
		if (done && state == stReadHi) begin
			hiByte <= result.rxByte;
		end
	end

endmodule

/* i2cMaster/i2cShifter.sv */
`timescale 1ns/1ns

module i2cShifter import i2cPkg::*; (
	input logic I2Cclk,
	input logic reset,
	input logic tick,
	input logic [1:0] phase,
	input shiftCmd_t cmd,
	input logic cmdGo,
	input logic sdaIn,
	output logic sdaDriveLow,
	output logic scl,
	output logic busy,
	output logic done,
	output shiftResult_t result
);

	shiftOp_t op;
	logic [7:0] shiftReg;
	logic masterAck;
	logic [3:0] bitCnt;
	logic started;
	logic ackBit;
	logic lastBit;

	assign ackBit = (bitCnt == 4'd8);
	assign lastBit = (op == opStart) || (op == opStop) || ackBit;

	always_ff @(posedge I2Cclk) begin
		if (reset) begin
			busy <= 1'b0;
			started <= 1'b0;
			done <= 1'b0;
			bitCnt <= 4'd0;
			sdaDriveLow <= 1'b0;
			scl <= 1'b1;
		end else begin
			done <= 1'b0;
			if (!busy) begin
				if (cmdGo) begin
					busy <= 1'b1;
					bitCnt <= 4'd0;
				end
			end else if (tick && (started || phase == 2'd0)) begin
				case (phase)
					2'd0: begin
						started <= 1'b1; // every operation begins on a bit boundary
						case (op)
							opStart: sdaDriveLow <= 1'b0;
							opStop: sdaDriveLow <= 1'b1;
							opWrite: sdaDriveLow <= ackBit ? 1'b0 : !shiftReg[7];
							default: sdaDriveLow <= ackBit ? !masterAck : 1'b0;
						endcase
					end
					2'd1: scl <= 1'b1;
					2'd2: begin
						if (op == opStart) begin
							sdaDriveLow <= 1'b1; // falling SDA with SCL high
						end else if (op == opStop) begin
							sdaDriveLow <= 1'b0; // rising SDA with SCL high
						end
					end
					default: begin
						scl <= (op == opStop); // the bus rests with SCL high
						if (lastBit) begin
							busy <= 1'b0;
							started <= 1'b0;
							done <= 1'b1;
						end else begin
							bitCnt <= bitCnt + 4'd1;
						end
					end
				endcase
			end
		end
	end

	always_ff @(posedge I2Cclk) begin
		if (cmdGo && !busy) begin
			op <= cmd.op;
			shiftReg <= cmd.txByte;
			masterAck <= cmd.masterAck;
		end else if (tick && started) begin
			if (phase == 2'd2 && ackBit) begin
				result.rxByte <= shiftReg;
				result.slaveNack <= (op == opWrite) && sdaIn; // released line means no ACK
			end else if (phase == 2'd2 && op == opRead) begin
				shiftReg <= {shiftReg[6:0], sdaIn}; // MSB arrives first
			end else if (phase == 2'd3 && op == opWrite && !ackBit) begin
				shiftReg <= {shiftReg[6:0], 1'b0};
			end
		end
	end

endmodule

/* i2cMaster/sclTimer.sv */
`timescale 1ns/1ns

module sclTimer import i2cPkg::*; (
	input logic I2Cclk,
	input logic reset,
	output logic tick,
	output logic [1:0] phase
);

	logic [quarterW-1:0] count;

	always_ff @(posedge I2Cclk) begin
		if (reset) begin
			count <= quarterW'(quarterTicks - 1);
			tick <= 1'b0;
		end else begin
			if (count == '0) begin
				count <= quarterW'(quarterTicks - 1);
				tick <= 1'b1;
			end else begin
				count <= count - 1'b1;
				tick <= 1'b0;
			end
		end
	end

	// phase moves on with the same edge that the shifter acts on the tick
	always_ff @(posedge I2Cclk) begin
		if (reset) begin
			phase <= 2'd0;
		end else if (tick) begin
			phase <= phase + 2'd1; // wraps from 3 back to 0
		end
	end

endmodule

/* runSim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module sensorReaderTb -f filelist.f -o simv &&
./obj_dir/simv || exit 1

/* tb/sensorReaderTb.sv */
`timescale 1ns/1ns

module sensorReaderTb import i2cPkg::*; ();

	localparam int clkPeriod = 20;
	localparam int resetCycles = 16;
	localparam int bitCycles = 4 * quarterTicks;
	localparam int numTrans = 9;
	localparam int nackTrans = 4; // the slave withholds its ACK on this pointer byte

	typedef enum logic [2:0] {
		slIdle, slAddrW, slPointer, slRestart, slAddrR, slDataHi, slDataLo, slStop
	} slaveStep_t;

	logic I2Cclk = 1'b0;
	logic reset;
	logic sdaIn = 1'b1;
	logic sdaDriveLow;
	logic scl;
	segDisplay_t segments;
	sensorReading_t reading;
	logic readingValid;
	ackStatus_t ackStatus;

	slaveStep_t step;
	int bitIdx; // SCL rises seen since the start of the current byte
	int transNum;
	logic [7:0] rxShift;
	logic [7:0] txShift;
	logic [31:0] rngState;
	sensorReading_t slaveValue;
	logic slaveRel = 1'b1;
	logic slaveNacked;
	logic prevScl = 1'b1;
	logic prevSda = 1'b1;
	logic transEnd;

	sensorReaderTop i_dut (
		.I2Cclk(I2Cclk),
		.reset(reset),
		.sdaIn(sdaIn),
		.sdaDriveLow(sdaDriveLow),
		.scl(scl),
		.segments(segments),
		.reading(reading),
		.readingValid(readingValid),
		.ackStatus(ackStatus)
	);

	always #(clkPeriod / 2) I2Cclk = ~I2Cclk;

	initial begin
		reset = 1'b1;
		repeat (resetCycles) @(posedge I2Cclk);
		reset <= 1'b0;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// common-cathode hex font, bits g down to a
	function automatic logic [6:0] hexToSegments(input logic [3:0] nib);
		case (nib)
			4'h0: return 7'h3F;
			4'h1: return 7'h06;
			4'h2: return 7'h5B;
			4'h3: return 7'h4F;
			4'h4: return 7'h66;
			4'h5: return 7'h6D;
			4'h6: return 7'h7D;
			4'h7: return 7'h07;
			4'h8: return 7'h7F;
			4'h9: return 7'h6F;
			4'hA: return 7'h77;
			4'hB: return 7'h7C;
			4'hC: return 7'h39;
			4'hD: return 7'h5E;
			4'hE: return 7'h79;
			default: return 7'h71;
		endcase
	endfunction

	function automatic segDisplay_t displayFor(input sensorReading_t value);
		segDisplay_t disp;
		disp.digit3 = hexToSegments(value[15:12]);
		disp.digit2 = hexToSegments(value[11:8]);
		disp.digit1 = hexToSegments(value[7:4]);
		disp.digit0 = hexToSegments(value[3:0]);
		return disp;
	endfunction

	task automatic abortRun(input string what);
		$display("%s", what);
		$display("Simulation FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic checkReading(input sensorReading_t got, input sensorReading_t exp);
		if (got !== exp) begin
			abortRun($sformatf("Fail at %0t ns: reading %h, expected %h", $time, got, exp));
		end
	endtask

	task automatic checkSegments(input segDisplay_t got, input segDisplay_t exp);
		if (got !== exp) begin
			abortRun($sformatf("Fail at %0t ns: segments %h, expected %h", $time, got, exp));
		end
	endtask

	task automatic checkAck(input ackStatus_t got, input ackStatus_t exp);
		if (got !== exp) begin
			abortRun($sformatf("Fail at %0t ns: ackStatus %b, expected %b", $time, got, exp));
		end
	endtask

	task automatic compareLevel(input logic got, input logic exp);
		if (got !== exp) begin
			abortRun($sformatf("Fail at %0t ns: scl %b, expected %b", $time, got, exp));
		end
	endtask

	// slave model on the wired-AND line, it moves SDA only after it has seen SCL low
	always @(posedge I2Cclk) begin
		logic curSda;
		logic nextRel;
		logic forceNack;
		logic [7:0] expByte;
		logic [31:0] nextRng;
		curSda = !sdaDriveLow && slaveRel;
		nextRel = slaveRel;
		forceNack = 1'b0;
		expByte = 8'h00;
		nextRng = xorshift(rngState);
		transEnd <= 1'b0;
		if (reset) begin
			step <= slIdle;
			bitIdx <= 0;
			transNum <= 0;
			slaveNacked <= 1'b0;
			rngState <= 32'd18;
			nextRel = 1'b1;
		end else if (scl && prevScl && prevSda && !curSda) begin
			bitIdx <= 0;
			if (step == slIdle) begin
				step <= slAddrW;
				rngState <= nextRng;
				slaveValue <= nextRng[15:0]; // new register value for every transaction
			end else if (step == slRestart) begin
				step <= slAddrR;
			end else begin
				abortRun($sformatf("slave model: a START arrived in the middle of step %s", step.name()));
			end
		end else if (scl && prevScl && !prevSda && curSda) begin
			if (step != slStop) begin
				abortRun($sformatf("slave model: a STOP arrived during step %s", step.name()));
			end else begin
				step <= slIdle;
				transNum <= transNum + 1;
				transEnd <= 1'b1;
			end
		end else if (scl && !prevScl) begin
			bitIdx <= bitIdx + 1;
			if (bitIdx < 8) begin
				rxShift <= {rxShift[6:0], curSda};
			end else if (bitIdx == 8 && (step == slDataHi || step == slDataLo)) begin
				if (curSda != (step == slDataLo)) begin
					abortRun("slave model: the master must ACK the high byte and NACK the low byte");
				end
			end
		end else if (!scl && prevScl) begin
			if (bitIdx == 8) begin
				if (step == slDataHi || step == slDataLo) begin
					nextRel = 1'b1; // the master owns the acknowledge bit
				end else begin
					case (step)
						slAddrW: expByte = {sensorAddr, 1'b0};
						slPointer: expByte = pointerReg;
						default: expByte = {sensorAddr, 1'b1};
					endcase
					if (rxShift != expByte) begin
						abortRun($sformatf("slave model: got byte %h in step %s, wanted %h",
							rxShift, step.name(), expByte));
					end else begin
						forceNack = (transNum == nackTrans) && (step == slPointer);
						slaveNacked <= forceNack;
						nextRel = forceNack;
					end
				end
			end else if (bitIdx == 9) begin
				bitIdx <= 0;
				nextRel = 1'b1;
				case (step)
					slAddrW: step <= slaveNacked ? slStop : slPointer;
					slPointer: step <= slaveNacked ? slStop : slRestart;
					slAddrR: begin
						step <= slDataHi;
						nextRel = slaveValue[15];
						txShift <= {slaveValue[14:8], 1'b0};
					end
					slDataHi: begin
						step <= slDataLo;
						nextRel = slaveValue[7];
						txShift <= {slaveValue[6:0], 1'b0};
					end
					default: step <= slStop;
				endcase
			end else if (bitIdx > 0 && (step == slDataHi || step == slDataLo)) begin
				nextRel = txShift[7];
				txShift <= {txShift[6:0], 1'b0};
			end
		end
		prevScl <= scl;
		prevSda <= curSda;
		slaveRel <= nextRel;
		sdaIn <= !sdaDriveLow && nextRel;
	end

	initial begin
		int doneTrans;
		int finished;
		logic gotReading;
		ackStatus_t expAck;
		segDisplay_t lastSeg;
		doneTrans = 0;
		gotReading = 1'b0;
		lastSeg = displayFor(16'h0000);
		@(negedge reset);
		@(negedge I2Cclk);
		checkSegments(segments, lastSeg);
		checkAck(ackStatus, '0);
		compareLevel(scl, 1'b1);
		while (doneTrans < numTrans) begin
			@(negedge I2Cclk);
			if (readingValid) begin
				if (transNum == nackTrans) begin
					abortRun("a reading strobe came in a transaction without a pointer ACK");
				end else begin
					checkReading(reading, slaveValue);
					@(negedge I2Cclk);
					lastSeg = displayFor(slaveValue); // display loads one cycle after the strobe
					checkSegments(segments, lastSeg);
					gotReading = 1'b1;
				end
			end else if (transEnd) begin
				finished = transNum - 1;
				expAck = '0;
				expAck.pointerNack = (finished == nackTrans);
				checkAck(ackStatus, expAck);
				checkSegments(segments, lastSeg);
				if (!gotReading && finished != nackTrans) begin
					abortRun($sformatf("transaction %0d ended without a reading strobe", finished));
				end else begin
					gotReading = 1'b0;
					doneTrans = doneTrans + 1;
				end
			end
		end
		$display("Simulation PASSED");
		$finish;
	end

	initial begin
		#(resetCycles * clkPeriod + numTrans * 60 * bitCycles * clkPeriod);
		abortRun("watchdog timeout, the transactions did not complete in time");
	end

endmodule

/* tb/sensorReader_props.sv */
`timescale 1ns/1ns

module sensorReaderProps import i2cPkg::*; (
	input logic I2Cclk,
	input logic reset,
	input logic scl,
	input logic sdaDriveLow,
	input logic readingValid,
	input shiftCmd_t cmd
);

	// the command stays on cmd while the shifter works on it
	sdaStableHigh: assert property (@(posedge I2Cclk) disable iff (reset)
		(scl && $past(scl) && !$stable(sdaDriveLow)) |-> (cmd.op == opStart || cmd.op == opStop))
		else $error("SDA changed while SCL was high outside a START or STOP");

	validPulse: assert property (@(posedge I2Cclk) disable iff (reset)
		readingValid |=> !readingValid)
		else $error("readingValid stayed high for more than one cycle");

	quietInReset: assert property (@(posedge I2Cclk) (reset && $past(reset)) |-> !sdaDriveLow)
		else $error("SDA was pulled low during reset");

endmodule

bind sensorReaderTop sensorReaderProps i_props (
	.I2Cclk(I2Cclk),
	.reset(reset),
	.scl(scl),
	.sdaDriveLow(sdaDriveLow),
	.readingValid(readingValid),
	.cmd(cmd)
);
